// ==== src/cache_axi_config.svh ====
`ifndef CACHE_AXI_CONFIG_SVH
`define CACHE_AXI_CONFIG_SVH

// number of cache ports in front of the arbiter
`define CACHE_PORT_NUM 2

// byte address width on the cache bus and the AXI side
`define CACHE_ADDR_LEN 32

// data word width, always full words
`define CACHE_DATA_LEN 32

// burst length field, holds beats minus one
`define CACHE_BURST_LEN 4

// words in the on-chip memory slave
`define MEM_DEPTH 256

// transaction id, port index sits in the low bits
`define AXI_ID_LEN 2

`endif

// ==== src/cache_axi_pkg.sv ====
`default_nettype none

`include "cache_axi_config.svh"

package cache_axi_pkg;

	// request side of one cache port
	typedef struct packed {
		// request phase
		logic valid;
		logic write;
		logic [`CACHE_BURST_LEN-1:0] burst_len;
		logic [`CACHE_ADDR_LEN-1:0] addr;
		// data phase
		// on writes the port offers a beat, on reads it can take one
		logic data_ok;
		logic data_last;
		logic [`CACHE_DATA_LEN/8-1:0] data_strobe;
		logic [`CACHE_DATA_LEN-1:0] w_data;
	} cache_bus_req_t;

	// response side of one cache port
	typedef struct packed {
		// request taken
		logic ready;
		// write beat accepted or read beat valid
		logic data_ok;
		// final read beat
		logic data_last;
		logic [`CACHE_DATA_LEN-1:0] r_data;
	} cache_bus_resp_t;

	// one-hot bridge states
	typedef enum logic [3:0] {
		IDLE = 4'b0001,
		ADDR = 4'b0010,
		DATA = 4'b0100,
		RESP = 4'b1000
	} bridge_state_e;

endpackage

`default_nettype wire

// ==== src/axi_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

interface axi_bus_if;

	// read address
	logic [`AXI_ID_LEN-1:0] ar_id;
	logic [`CACHE_ADDR_LEN-1:0] ar_addr;
	logic [`CACHE_BURST_LEN-1:0] ar_len;
	logic ar_valid;
	logic ar_ready;

	// read data
	logic [`AXI_ID_LEN-1:0] r_id;
	logic [`CACHE_DATA_LEN-1:0] r_data;
	logic r_last;
	logic r_valid;
	logic r_ready;

	// write address
	logic [`AXI_ID_LEN-1:0] aw_id;
	logic [`CACHE_ADDR_LEN-1:0] aw_addr;
	logic [`CACHE_BURST_LEN-1:0] aw_len;
	logic aw_valid;
	logic aw_ready;

	// write data, no id on W
	logic [`CACHE_DATA_LEN-1:0] w_data;
	logic [`CACHE_DATA_LEN/8-1:0] w_strb;
	logic w_last;
	logic w_valid;
	logic w_ready;

	// write response
	logic [`AXI_ID_LEN-1:0] b_id;
	logic b_valid;
	logic b_ready;

	modport master (
		output ar_id, ar_addr, ar_len, ar_valid, input ar_ready,
		input r_id, r_data, r_last, r_valid, output r_ready,
		output aw_id, aw_addr, aw_len, aw_valid, input aw_ready,
		output w_data, w_strb, w_last, w_valid, input w_ready,
		input b_id, b_valid, output b_ready
	);

	modport slave (
		input ar_id, ar_addr, ar_len, ar_valid, output ar_ready,
		output r_id, r_data, r_last, r_valid, input r_ready,
		input aw_id, aw_addr, aw_len, aw_valid, output aw_ready,
		input w_data, w_strb, w_last, w_valid, output w_ready,
		output b_id, b_valid, input b_ready
	);

endinterface

`default_nettype wire

// ==== src/rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module rr_arbiter #(
	parameter int REQ_NUM = `CACHE_PORT_NUM
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [REQ_NUM-1:0] req_i,
	input wire logic take_i,
	output logic [REQ_NUM-1:0] sel_o
);

	localparam int PTR_W = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

	logic [PTR_W-1:0] ptr_q;
	logic [PTR_W-1:0] gnt_idx;
	logic found;
	int idx;

	// search from the pointer and wrap around
	always_comb begin
		sel_o = '0;
		gnt_idx = '0;
		found = 1'b0;
		idx = 0;
		for (int k = 0; k < REQ_NUM; k++) begin
			idx = (int'(ptr_q) + k) % REQ_NUM;
			if (take_i && !found && req_i[idx]) begin
				sel_o[idx] = 1'b1;
				gnt_idx = PTR_W'(idx);
				found = 1'b1;
			end
		end
	end

	// pointer moves one past the winner
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (found) begin
			ptr_q <= PTR_W'((int'(gnt_idx) + 1) % REQ_NUM);
		end
	end

endmodule

`default_nettype wire

// ==== src/cache_axi_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module cache_axi_bridge
	import cache_axi_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire cache_bus_req_t [`CACHE_PORT_NUM-1:0] req_i,
	output cache_bus_resp_t [`CACHE_PORT_NUM-1:0] resp_o,
	axi_bus_if.master axi
);

	localparam int PORTS = `CACHE_PORT_NUM;
	localparam int IDX_W = (PORTS > 1) ? $clog2(PORTS) : 1;
	localparam int ID_W = `AXI_ID_LEN;

	bridge_state_e state_q, state_d;

	logic take;
	logic [PORTS-1:0] req_valid;
	logic [PORTS-1:0] sel_comb;
	logic [PORTS-1:0] sel_q;
	logic [IDX_W-1:0] sel_idx;
	logic [ID_W-1:0] txn_id;

	// latched request of the winner
	logic wr_q;
	logic [`CACHE_BURST_LEN-1:0] len_q;
	logic [`CACHE_ADDR_LEN-1:0] addr_q;

	// grant-side and data-side views of the port inputs
	cache_bus_req_t win_req;
	cache_bus_req_t act_req;

	logic r_hit;
	logic b_hit;

	assign take = (state_q == IDLE);

	for (genvar i = 0; i < PORTS; i++) begin : g_port
		assign req_valid[i] = req_i[i].valid;
		assign resp_o[i].ready = sel_comb[i];
		assign resp_o[i].data_ok = sel_q[i] && (state_q == DATA) &&
			(wr_q ? (axi.w_valid && axi.w_ready) : r_hit);
		assign resp_o[i].data_last = sel_q[i] && (state_q == DATA) && !wr_q &&
			r_hit && axi.r_last;
		assign resp_o[i].r_data = axi.r_data;
	end

	rr_arbiter #(
		.REQ_NUM(PORTS)
	) u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.req_i(req_valid),
		.take_i(take),
		.sel_o(sel_comb)
	);

	// granted port for the latch, active port for the data phase
	always_comb begin
		win_req = '0;
		act_req = '0;
		sel_idx = '0;
		for (int i = 0; i < PORTS; i++) begin
			if (sel_comb[i]) begin
				win_req = req_i[i];
			end
			if (sel_q[i]) begin
				act_req = req_i[i];
				sel_idx = IDX_W'(i);
			end
		end
	end

	assign txn_id = ID_W'(sel_idx);
	assign r_hit = axi.r_valid && (axi.r_id == txn_id);
	assign b_hit = axi.b_valid && (axi.b_id == txn_id);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_q <= '0;
			wr_q <= 1'b0;
		end else if (take && |sel_comb) begin
			sel_q <= sel_comb;
			wr_q <= win_req.write;
		end
	end

	always_ff @(posedge clk) begin
		if (take && |sel_comb) begin
			len_q <= win_req.burst_len;
			addr_q <= win_req.addr;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (|sel_comb) begin
					state_d = ADDR;
				end
			end
			ADDR: begin
				if ((axi.ar_valid && axi.ar_ready) || (axi.aw_valid && axi.aw_ready)) begin
					state_d = DATA;
				end
			end
			DATA: begin
				if (!wr_q && r_hit && axi.r_ready && axi.r_last) begin
					state_d = IDLE;
				end else if (wr_q && axi.w_valid && axi.w_ready && axi.w_last) begin
					state_d = RESP;
				end
			end
			RESP: begin
				if (b_hit && axi.b_ready) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address channels straight from the latched request
	assign axi.ar_id = txn_id;
	assign axi.ar_addr = addr_q;
	assign axi.ar_len = len_q;
	assign axi.ar_valid = (state_q == ADDR) && !wr_q;
	assign axi.aw_id = txn_id;
	assign axi.aw_addr = addr_q;
	assign axi.aw_len = len_q;
	assign axi.aw_valid = (state_q == ADDR) && wr_q;

	// write beats follow the port, no staging register
	assign axi.w_data = act_req.w_data;
	assign axi.w_strb = act_req.data_strobe;
	assign axi.w_valid = (state_q == DATA) && wr_q && act_req.data_ok;
	assign axi.w_last = (state_q == DATA) && wr_q && act_req.data_last;

	assign axi.r_ready = (state_q == DATA) && !wr_q && act_req.data_ok;
	assign axi.b_ready = (state_q == RESP);

endmodule

`default_nettype wire

// ==== src/axi_mem_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module axi_mem_slave (
	input wire logic clk,
	input wire logic rst_n,
	axi_bus_if.slave axi
);

	localparam int WA_W = $clog2(`MEM_DEPTH);
	localparam int STRB_W = `CACHE_DATA_LEN / 8;

	logic [`CACHE_DATA_LEN-1:0] mem_q [`MEM_DEPTH];

	// control state
	logic rd_active_q;
	logic wr_active_q;
	logic b_valid_q;

	// burst context, shared by reads and writes
	logic [`AXI_ID_LEN-1:0] id_q;
	logic [WA_W-1:0] word_q;
	logic [`CACHE_BURST_LEN-1:0] cnt_q;

	logic idle;
	logic ar_hs;
	logic aw_hs;
	logic r_hs;
	logic w_hs;

	assign idle = !rd_active_q && !wr_active_q && !b_valid_q;

	// AR wins if both ever show up together
	assign axi.ar_ready = idle;
	assign axi.aw_ready = idle && !axi.ar_valid;

	assign ar_hs = axi.ar_valid && axi.ar_ready;
	assign aw_hs = axi.aw_valid && axi.aw_ready;
	assign r_hs = axi.r_valid && axi.r_ready;
	assign w_hs = axi.w_valid && axi.w_ready;

	// read beat comes straight from the array, holds while r_ready is low
	assign axi.r_valid = rd_active_q;
	assign axi.r_id = id_q;
	assign axi.r_data = mem_q[word_q];
	assign axi.r_last = rd_active_q && (cnt_q == '0);

	assign axi.w_ready = wr_active_q;

	assign axi.b_valid = b_valid_q;
	assign axi.b_id = id_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_active_q <= 1'b0;
			wr_active_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (ar_hs) begin
				rd_active_q <= 1'b1;
			end else if (r_hs && axi.r_last) begin
				rd_active_q <= 1'b0;
			end
			if (aw_hs) begin
				wr_active_q <= 1'b1;
			end else if (w_hs && axi.w_last) begin
				wr_active_q <= 1'b0;
			end
			// response one cycle after the last write beat
			if (w_hs && axi.w_last) begin
				b_valid_q <= 1'b1;
			end else if (axi.b_ready) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			id_q <= axi.ar_id;
			word_q <= axi.ar_addr[WA_W+1:2];
			cnt_q <= axi.ar_len;
		end else if (aw_hs) begin
			id_q <= axi.aw_id;
			word_q <= axi.aw_addr[WA_W+1:2];
			cnt_q <= axi.aw_len;
		end else if (r_hs || w_hs) begin
			word_q <= word_q + 1'b1;
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// byte lanes under strobe
	always_ff @(posedge clk) begin
		if (w_hs) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (axi.w_strb[b]) begin
					mem_q[word_q][8*b +: 8] <= axi.w_data[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/cache_axi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module cache_axi_top
	import cache_axi_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire cache_bus_req_t [`CACHE_PORT_NUM-1:0] req_i,
	output cache_bus_resp_t [`CACHE_PORT_NUM-1:0] resp_o
);

	// bridge to memory link
	axi_bus_if axi_bus ();

	cache_axi_bridge u_bridge (
		.clk(clk),
		.rst_n(rst_n),
		.req_i(req_i),
		.resp_o(resp_o),
		.axi(axi_bus.master)
	);

	// on-chip memory closes the bus
	axi_mem_slave u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.axi(axi_bus.slave)
	);

endmodule

`default_nettype wire

// ==== dv/cache_axi_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module cache_axi_assert
	import cache_axi_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire bridge_state_e state_i,
	input wire logic ar_valid_i,
	input wire logic ar_ready_i,
	input wire logic aw_valid_i,
	input wire logic aw_ready_i,
	input wire cache_bus_resp_t [`CACHE_PORT_NUM-1:0] resp_i
);

	// failed assertions so far
	int violations = 0;
	logic [`CACHE_PORT_NUM-1:0] ready_vec;

	always_comb begin
		for (int i = 0; i < `CACHE_PORT_NUM; i++) begin
			ready_vec[i] = resp_i[i].ready;
		end
	end

	state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_i))
		else begin
			$error("bridge state is not one-hot");
			violations++;
		end

	// only one address channel at a time
	addr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(ar_valid_i && aw_valid_i))
		else begin
			$error("ar_valid and aw_valid high together");
			violations++;
		end

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid_i && !ar_ready_i |=> ar_valid_i)
		else begin
			$error("ar_valid dropped before ar_ready");
			violations++;
		end

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		aw_valid_i && !aw_ready_i |=> aw_valid_i)
		else begin
			$error("aw_valid dropped before aw_ready");
			violations++;
		end

	ready_single: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ready_vec))
		else begin
			$error("more than one cache port sees ready");
			violations++;
		end

endmodule

bind cache_axi_bridge cache_axi_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.state_i(state_q),
	.ar_valid_i(axi.ar_valid),
	.ar_ready_i(axi.ar_ready),
	.aw_valid_i(axi.aw_valid),
	.aw_ready_i(axi.aw_ready),
	.resp_i(resp_o)
);

`default_nettype wire

// ==== dv/tb_cache_axi.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_axi_config.svh"

module tb_cache_axi
	import cache_axi_pkg::*;
();

	localparam int PORTS = `CACHE_PORT_NUM;
	localparam int RST_CYCLES = 16;
	localparam int TXN_NUM = 20;
	localparam int TXN_CYCLES = 8;
	localparam int BEAT_NUM = 52;
	localparam int STALL_MAX = 3;
	localparam int MARGIN = 200;
	// two resets, per-transaction overhead, every beat stalled as long as possible
	localparam int WORST_CYCLES = 2 * (RST_CYCLES + 2) + TXN_NUM * TXN_CYCLES +
		BEAT_NUM * (STALL_MAX + 1) + MARGIN;

	logic clk;
	logic rst_n;
	cache_bus_req_t [PORTS-1:0] req;
	cache_bus_resp_t [PORTS-1:0] resp;

	// scoreboard memory and expected arbiter pointer
	logic [`CACHE_DATA_LEN-1:0] model_mem [`MEM_DEPTH];
	int rr_ptr;
	integer seed;

	cache_axi_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.req_i(req),
		.resp_o(resp)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [`CACHE_DATA_LEN-1:0] exp,
		input logic [`CACHE_DATA_LEN-1:0] act);
		if (act !== exp) begin
			stop_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_run($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp, act));
		end
	endtask

	// memory word of a beat, above the byte offset
	function automatic int word_of(input logic [`CACHE_ADDR_LEN-1:0] addr, input int beat);
		return int'(((addr >> 2) + beat) % `MEM_DEPTH);
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		req = '0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		rr_ptr = 0;
	endtask

	task automatic drive_request(input int p, input logic wr,
		input logic [`CACHE_BURST_LEN-1:0] len, input logic [`CACHE_ADDR_LEN-1:0] addr);
		req[p].valid = 1'b1;
		req[p].write = wr;
		req[p].burst_len = len;
		req[p].addr = addr;
	endtask

	// hold valid until ready, the pointer then moves past this port
	task automatic wait_grant(input int p);
		#1;
		while (!resp[p].ready) begin
			@(negedge clk);
			#1;
		end
		rr_ptr = (p + 1) % PORTS;
		@(negedge clk);
		req[p].valid = 1'b0;
	endtask

	task automatic write_beats(input int p, input logic [`CACHE_ADDR_LEN-1:0] addr,
		input logic [`CACHE_BURST_LEN-1:0] len, input logic [`CACHE_DATA_LEN/8-1:0] strb);
		logic [`CACHE_DATA_LEN-1:0] data;
		int w;
		for (int b = 0; b <= int'(len); b++) begin
			data = $random(seed);
			w = word_of(addr, b);
			@(negedge clk);
			req[p].data_ok = 1'b1;
			req[p].data_last = (b == int'(len));
			req[p].w_data = data;
			req[p].data_strobe = strb;
			#1;
			while (!resp[p].data_ok) begin
				@(negedge clk);
				#1;
			end
			// beat is taken at the coming edge
			for (int k = 0; k < `CACHE_DATA_LEN / 8; k++) begin
				if (strb[k]) begin
					model_mem[w][8*k +: 8] = data[8*k +: 8];
				end
			end
		end
		@(negedge clk);
		req[p].data_ok = 1'b0;
		req[p].data_last = 1'b0;
	endtask

	task automatic read_beats(input int p, input logic [`CACHE_ADDR_LEN-1:0] addr,
		input logic [`CACHE_BURST_LEN-1:0] len, input bit stall);
		int b;
		int gap;
		string tag;
		b = 0;
		tag = $sformatf("resp[%0d]", p);
		while (b <= int'(len)) begin
			if (stall) begin
				gap = {$random(seed)} % (STALL_MAX + 1);
				repeat (gap) begin
					@(negedge clk);
					req[p].data_ok = 1'b0;
				end
			end
			@(negedge clk);
			req[p].data_ok = 1'b1;
			#1;
			if (resp[p].data_ok) begin
				check_word({tag, ".r_data"}, model_mem[word_of(addr, b)], resp[p].r_data);
				check_flag({tag, ".data_last"}, b == int'(len), resp[p].data_last);
				b++;
			end
		end
		@(negedge clk);
		req[p].data_ok = 1'b0;
	endtask

	task automatic write_burst(input int p, input logic [`CACHE_ADDR_LEN-1:0] addr,
		input logic [`CACHE_BURST_LEN-1:0] len, input logic [`CACHE_DATA_LEN/8-1:0] strb);
		@(negedge clk);
		drive_request(p, 1'b1, len, addr);
		wait_grant(p);
		write_beats(p, addr, len, strb);
	endtask

	task automatic read_burst(input int p, input logic [`CACHE_ADDR_LEN-1:0] addr,
		input logic [`CACHE_BURST_LEN-1:0] len, input bit stall);
		@(negedge clk);
		drive_request(p, 1'b0, len, addr);
		wait_grant(p);
		read_beats(p, addr, len, stall);
	endtask

	task automatic test_reset_state();
		repeat (4) begin
			@(negedge clk);
			#1;
			for (int p = 0; p < PORTS; p++) begin
				check_flag($sformatf("resp[%0d].ready", p), 1'b0, resp[p].ready);
				check_flag($sformatf("resp[%0d].data_ok", p), 1'b0, resp[p].data_ok);
				check_flag($sformatf("resp[%0d].data_last", p), 1'b0, resp[p].data_last);
			end
		end
	endtask

	task automatic test_single_word();
		for (int p = 0; p < PORTS; p++) begin
			write_burst(p, 32'h10 + 32'h40 * p, 4'd0, 4'hf);
			read_burst(p, 32'h10 + 32'h40 * p, 4'd0, 1'b0);
		end
	endtask

	task automatic test_burst4();
		write_burst(0, 32'h100, 4'd3, 4'hf);
		read_burst(0, 32'h100, 4'd3, 1'b0);
	endtask

	task automatic test_partial_strobe();
		write_burst(0, 32'h200, 4'd1, 4'hf);
		write_burst(0, 32'h200, 4'd1, 4'b0101);
		read_burst(0, 32'h200, 4'd1, 1'b0);
	endtask

	task automatic test_round_robin();
		int first;
		int second;
		logic [`CACHE_ADDR_LEN-1:0] base;
		apply_reset();
		for (int r = 0; r < 2; r++) begin
			first = rr_ptr;
			second = (rr_ptr + 1) % PORTS;
			base = 32'h300 + 32'h40 * r;
			@(negedge clk);
			for (int p = 0; p < PORTS; p++) begin
				drive_request(p, 1'b1, 4'd1, base + 32'h20 * p);
			end
			#1;
			check_flag($sformatf("resp[%0d].ready", first), 1'b1, resp[first].ready);
			check_flag($sformatf("resp[%0d].ready", second), 1'b0, resp[second].ready);
			wait_grant(first);
			write_beats(first, base + 32'h20 * first, 4'd1, 4'hf);
			// the other port kept valid up and goes next
			wait_grant(second);
			write_beats(second, base + 32'h20 * second, 4'd1, 4'hf);
			read_burst(first, base + 32'h20 * first, 4'd1, 1'b0);
			read_burst(second, base + 32'h20 * second, 4'd1, 1'b0);
			// one more port 0 access leaves the pointer on port 1
			if (r == 0) begin
				read_burst(0, base, 4'd1, 1'b0);
			end
		end
	endtask

	task automatic test_backpressure();
		write_burst(1, 32'h380, 4'd7, 4'hf);
		read_burst(1, 32'h380, 4'd7, 1'b1);
	endtask

	initial begin
		seed = 64;
		rst_n = 1'b0;
		req = '0;
		rr_ptr = 0;
		apply_reset();
		test_reset_state();
		test_single_word();
		test_burst4();
		test_partial_strobe();
		test_round_robin();
		test_backpressure();
		repeat (4) @(negedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

	// bound checker on the bridge
	initial begin
		wait (dut_i.u_bridge.u_assert.violations != 0);
		stop_run("an assertion on the bridge reported a violation");
	end

	// watchdog
	initial begin
		#(WORST_CYCLES * 20);
		stop_run("timeout, the tests did not finish within the expected number of cycles");
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/cache_axi_pkg.sv
src/axi_bus_if.sv
src/rr_arbiter.sv
src/cache_axi_bridge.sv
src/axi_mem_slave.sv
src/cache_axi_top.sv
dv/cache_axi_assert.sv
dv/tb_cache_axi.sv

// ==== Bender.yml ====
package:
  name: cache_axi

export_include_dirs:
  - src

sources:
  - files:
      - src/cache_axi_pkg.sv
      - src/axi_bus_if.sv
      - src/rr_arbiter.sv
      - src/cache_axi_bridge.sv
      - src/axi_mem_slave.sv
      - src/cache_axi_top.sv
  - target: simulation
    files:
      - dv/cache_axi_assert.sv
      - dv/tb_cache_axi.sv
